/* compile.f */
+incdir+src
src/conv_pkg.sv
src/line_mem.sv
src/window_linebuf.sv
src/window_mac.sv
src/conv_apb_regs.sv
src/conv_top.sv
test/conv_asserts.sv
test/conv_tb.sv

/* Makefile */
TOP = conv_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then \
	  echo "simulation failed, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* test/conv_tb.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_tb import conv_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4 * (3 * 33 * 32 + 200);
  localparam int NPIX = (`MAXSIZE + 1) * `MAXSIZE; // image plus flush row

  logic     clk;
  logic     xrst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  pixel_t   pix_in;
  logic     busy;
  pixel_t   res_data;
  logic     res_valid;

  pixel_t   img_mem [NPIX];
  pixel_t   exp_q [$];
  int       pix_idx;
  int       cycles;
  int       busy_len;
  int       res_count;
  int       value_errors;
  int       timeouts;
  int       seed;
  string    test_name;

  conv_top u_dut (
    .clk       (clk),
    .xrst      (xrst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .pix_in    (pix_in),
    .busy      (busy),
    .res_data  (res_data),
    .res_valid (res_valid)
  );

  bind conv_top conv_asserts u_asserts (
    .clk       (clk),
    .xrst      (xrst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .start     (start),
    .busy      (busy),
    .win_valid (win_valid),
    .res_valid (res_valid)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("Fail %s (%s): expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value("pready", 1, int'(apb_rsp.pready)); // no wait states
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input int data, input bit exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value("write pslverr", int'(exp_err), int'(err));
  endtask

  task automatic apb_read(input logic [7:0] addr, input int exp_data, input bit exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_value("read pslverr", int'(exp_err), int'(err));
    if (!exp_err) begin
      check_value("read data", exp_data, int'(rdata));
    end
  endtask

  // ones: top-left fil x fil block of 1, otherwise a single 1 at row 0, column 0
  task automatic load_kernel(input int fil, input bit ones);
    int w;
    for (int i = 0; i < `MAXLINE * `MAXLINE; i++) begin
      if (ones) begin
        w = (i / `MAXLINE < fil && i % `MAXLINE < fil) ? 1 : 0;
      end else begin
        w = (i == 0) ? 1 : 0;
      end
      apb_write(8'(`REG_WGT + 4 * i), w, 1'b0);
    end
  endtask

  task automatic run_frame(input string name, input int img, input int fil,
                           input bit rand_pix, input bit busy_write);
    int nres;
    test_name = name;
    nres = (img - fil + 1) * (img - fil + 1);
    apb_write(`REG_IMG, img, 1'b0);
    apb_write(`REG_FIL, fil, 1'b0);
    load_kernel(fil, !rand_pix);
    for (int i = 0; i < NPIX; i++) begin
      img_mem[i] = rand_pix ? pixel_t'($random(seed)) : pixel_t'(3);
    end
    for (int r = 0; r <= img - fil; r++) begin
      for (int c = 0; c <= img - fil; c++) begin
        exp_q.push_back(rand_pix ? img_mem[r * img + c] : pixel_t'(3 * fil * fil));
      end
    end
    busy_len  = 0;
    res_count = 0;
    apb_write(`REG_CTRL, 1, 1'b0);
    wait (busy === 1'b1);
    if (busy_write) begin
      apb_write(`REG_CTRL, 1, 1'b1); // rejected, frame goes on
    end
    wait (busy === 1'b0);
    wait (res_count == nres);
    repeat (4) @(posedge clk); // pipeline depth, catches extra results
    check_value("busy cycles", img * (img + 1), busy_len);
    check_value("result count", nres, res_count);
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = u_dut.u_asserts.fail_count;
    $display("errors: values %0d, assertions %0d, timeouts %0d",
             value_errors, assert_errors, timeouts);
    if (value_errors + assert_errors + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // pixel k is on pix_in at the k-th busy edge
  always @(posedge clk) begin
    if (busy === 1'b1) begin
      pix_idx <= pix_idx + 1;
      pix_in  <= img_mem[(pix_idx + 1) % NPIX];
    end else begin
      pix_idx <= 0;
      pix_in  <= img_mem[0];
    end
  end

  always @(negedge clk) begin
    if (busy === 1'b1) begin
      busy_len++;
    end
    if (res_valid === 1'b1) begin
      res_count++;
      if (exp_q.size() == 0) begin
        value_errors++;
        $display("%s: a result arrived with no window expected", test_name);
      end else begin
        check_value("res_data", int'(exp_q.pop_front()), int'(res_data));
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    timeouts++;
    $display("Timeout: run still going after %0d cycles", cycles);
    finish_run();
  end

  initial begin
    clk          = 1'b0;
    xrst         = 1'b0;
    apb_req      = '0;
    pix_in       = '0;
    pix_idx      = 0;
    value_errors = 0;
    timeouts     = 0;
    seed         = 75;
    test_name    = "reset";
    for (int i = 0; i < NPIX; i++) begin
      img_mem[i] = '0;
    end
    repeat (4) @(posedge clk);
    xrst <= 1'b1;

    test_name = "register readback";
    apb_write(`REG_IMG, 12, 1'b0);
    apb_write(`REG_FIL, 4, 1'b0);
    apb_write(8'(`REG_WGT + 8'h08), -5, 1'b0);
    apb_read(`REG_IMG, 12, 1'b0);
    apb_read(`REG_FIL, 4, 1'b0);
    apb_read(8'(`REG_WGT + 8'h08), -5, 1'b0);
    apb_read(`REG_STATUS, 0, 1'b0);
    apb_read(8'h20, 0, 1'b1); // unmapped

    run_frame("frame 8/3 constant", 8, 3, 1'b0, 1'b1);
    run_frame("frame 6/5 constant", 6, 5, 1'b0, 1'b0);
    run_frame("frame 8/3 random", 8, 3, 1'b1, 1'b0);
    finish_run();
  end

endmodule

/* test/conv_asserts.sv */
`timescale 1ns/1ns

module conv_asserts import conv_pkg::*; (
  input logic     clk,
  input logic     xrst,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp,
  input logic     start,
  input logic     busy,
  input logic     win_valid,
  input logic     res_valid
);

  int unsigned fail_count = 0;

  // access phase only directly after a setup phase
  penable_after_setup: assert property (@(posedge clk) disable iff (!xrst)
      apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
    else begin
      fail_count++;
      $error("penable high without a preceding setup cycle");
    end

  pslverr_in_access: assert property (@(posedge clk) disable iff (!xrst)
      apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
    else begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

  busy_after_start: assert property (@(posedge clk) disable iff (!xrst)
      $rose(busy) |-> $past(start))
    else begin
      fail_count++;
      $error("busy rose without a start pulse one cycle before");
    end

  start_sets_busy: assert property (@(posedge clk) disable iff (!xrst)
      start && !busy |=> busy)
    else begin
      fail_count++;
      $error("start pulse did not raise busy on the next cycle");
    end

  // two MAC stages between window and result
  res_after_win: assert property (@(posedge clk) disable iff (!xrst)
      win_valid |-> ##2 res_valid)
    else begin
      fail_count++;
      $error("res_valid missing two cycles after win_valid");
    end

  res_has_win: assert property (@(posedge clk) disable iff (!xrst)
      res_valid |-> $past(win_valid, 2))
    else begin
      fail_count++;
      $error("res_valid without a window two cycles earlier");
    end

  reset_quiet: assert property (@(posedge clk)
      !xrst |=> !busy && !res_valid && !apb_rsp.pslverr)
    else begin
      fail_count++;
      $error("busy, res_valid or pslverr high during reset");
    end

endmodule

/* src/conv_top.sv */
`timescale 1ns/1ns

module conv_top import conv_pkg::*; (
  input  logic     clk,
  input  logic     xrst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  input  pixel_t   pix_in,
  output logic     busy,
  output pixel_t   res_data,
  output logic     res_valid
);

  conv_cfg_t cfg;
  kernel_t   kernel;
  window_t   window;
  logic      start;
  logic      win_valid;

  conv_apb_regs u_regs (
    .clk     (clk),
    .xrst    (xrst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .busy    (busy),
    .cfg     (cfg),
    .kernel  (kernel),
    .start   (start)
  );

  window_linebuf u_linebuf (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .pix_in    (pix_in),
    .busy      (busy),
    .window    (window),
    .win_valid (win_valid)
  );

  window_mac u_mac (
    .clk       (clk),
    .xrst      (xrst),
    .window    (window),
    .win_valid (win_valid),
    .kernel    (kernel),
    .res_data  (res_data),
    .res_valid (res_valid)
  );

endmodule

/* src/conv_apb_regs.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module conv_apb_regs import conv_pkg::*; (
  input  logic      clk,
  input  logic      xrst,
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  input  logic      busy,
  output conv_cfg_t cfg,
  output kernel_t   kernel,
  output logic      start
);

  localparam int NWGT = `MAXLINE * `MAXLINE;
  localparam logic [`APB_AWIDTH-1:0] WGT_LAST = `APB_AWIDTH'(`REG_WGT + 4 * (NWGT - 1));

  logic                   setup;
  logic                   access;
  logic                   wr_ok;
  logic                   hit_ctrl;
  logic                   hit_status;
  logic                   hit_img;
  logic                   hit_fil;
  logic                   hit_wgt;
  logic                   bad;
  logic [4:0]             wgt_idx;
  logic [`APB_DWIDTH-1:0] rd_mux;
  logic [`APB_DWIDTH-1:0] rdata_q;
  logic                   err_q;

  assign setup  = apb_req.psel && !apb_req.penable;
  assign access = apb_req.psel && apb_req.penable;
  assign wr_ok  = access && apb_req.pwrite && !err_q;

  assign hit_ctrl   = apb_req.paddr == `REG_CTRL;
  assign hit_status = apb_req.paddr == `REG_STATUS;
  assign hit_img    = apb_req.paddr == `REG_IMG;
  assign hit_fil    = apb_req.paddr == `REG_FIL;
  assign hit_wgt    = apb_req.paddr >= `REG_WGT && apb_req.paddr <= WGT_LAST
                      && apb_req.paddr[1:0] == 2'b00;
  assign wgt_idx    = 5'((apb_req.paddr - `REG_WGT) >> 2);

  // unmapped offset, or a start attempt during a frame
  assign bad = !(hit_ctrl || hit_status || hit_img || hit_fil || hit_wgt)
               || (apb_req.pwrite && hit_ctrl && busy);

  always_comb begin
    rd_mux = '0;
    if (hit_status) begin
      rd_mux = `APB_DWIDTH'(busy);
    end else if (hit_img) begin
      rd_mux = `APB_DWIDTH'(cfg.img_size);
    end else if (hit_fil) begin
      rd_mux = `APB_DWIDTH'(cfg.fil_size);
    end else if (hit_wgt) begin
      rd_mux = `APB_DWIDTH'($signed(kernel[wgt_idx])); // sign extended
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      rdata_q <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      err_q  <= 1'b0;
      start  <= 1'b0;
      cfg    <= '{img_size: size_t'(`MAXSIZE), fil_size: size_t'(`MAXLINE)};
      kernel <= '0;
    end else begin
      err_q <= setup && bad;
      start <= wr_ok && hit_ctrl && apb_req.pwdata[0]; // one cycle pulse
      if (wr_ok && hit_img) begin
        cfg.img_size <= apb_req.pwdata[`LWIDTH-1:0];
      end
      if (wr_ok && hit_fil) begin
        cfg.fil_size <= apb_req.pwdata[`LWIDTH-1:0];
      end
      if (wr_ok && hit_wgt) begin
        kernel[wgt_idx] <= apb_req.pwdata[`WWIDTH-1:0];
      end
    end
  end

  assign apb_rsp = '{prdata: rdata_q, pready: 1'b1, pslverr: err_q};

endmodule

/* src/window_mac.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module window_mac import conv_pkg::*; (
  input  logic    clk,
  input  logic    xrst,
  input  window_t window,
  input  logic    win_valid,
  input  kernel_t kernel,
  output pixel_t  res_data,
  output logic    res_valid
);

  localparam int NTAP   = `MAXLINE * `MAXLINE;
  localparam int TPAD   = 2 ** $clog2(NTAP);
  localparam int PWIDTH = `DWIDTH + `WWIDTH;
  localparam int SWIDTH = PWIDTH + $clog2(NTAP);

  logic signed [PWIDTH-1:0] prod_q [NTAP];
  logic                     prod_valid;
  logic signed [SWIDTH-1:0] node [1:2*TPAD-1]; // heap order, node 1 is the root

  // stage one
  always_ff @(posedge clk) begin
    for (int i = 0; i < NTAP; i++) begin
      prod_q[i] <= $signed(window[i]) * $signed(kernel[i]);
    end
  end

  for (genvar i = 0; i < TPAD; i++) begin : g_leaf
    if (i < NTAP) begin : g_tap
      assign node[TPAD + i] = prod_q[i];
    end else begin : g_pad
      assign node[TPAD + i] = '0;
    end
  end

  for (genvar n = 1; n < TPAD; n++) begin : g_add
    assign node[n] = node[2*n] + node[2*n + 1];
  end

  // stage two, truncated to pixel width
  always_ff @(posedge clk) begin
    res_data <= node[1][`DWIDTH-1:0];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      prod_valid <= 1'b0;
      res_valid  <= 1'b0;
    end else begin
      prod_valid <= win_valid;
      res_valid  <= prod_valid;
    end
  end

endmodule

/* src/window_linebuf.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module window_linebuf import conv_pkg::*; (
  input  logic      clk,
  input  logic      xrst,
  input  logic      start,
  input  conv_cfg_t cfg,
  input  pixel_t    pix_in,
  output logic      busy,
  output window_t   window,
  output logic      win_valid
);

  localparam int NMEM   = `MAXLINE + 1;
  localparam int SWIDTH = $clog2(NMEM);
  localparam int AWIDTH = $clog2(`MAXSIZE);

  linebuf_state_t    state;
  size_t             col;
  size_t             line;
  logic [SWIDTH-1:0] wr_slot;
  logic [SWIDTH-1:0] slot_q;
  logic              row_end;
  logic              charge_end;
  logic              frame_end;
  logic              take_d;
  pixel_t            rd_data [NMEM];
  pixel_t            col_pix [`MAXLINE];
  window_t           win_next;

  // memory slot holding image row (current row - fil + row)
  function automatic logic [SWIDTH-1:0] row_slot(logic [SWIDTH-1:0] base, size_t fil, int row);
    int s;
    s = int'(base) + NMEM + row - int'(fil);
    return SWIDTH'(s % NMEM);
  endfunction

  assign busy       = state != LB_WAIT;
  assign row_end    = col == cfg.img_size - size_t'(1);
  assign charge_end = row_end && line == cfg.fil_size - size_t'(1);
  assign frame_end  = row_end && line == cfg.img_size; // one flush row after the image

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= LB_WAIT;
    end else begin
      case (state)
        LB_WAIT:   if (start) state <= LB_CHARGE;
        LB_CHARGE: if (charge_end) state <= LB_ACTIVE;
        LB_ACTIVE: if (frame_end) state <= LB_WAIT;
        default:   state <= LB_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col     <= '0;
      line    <= '0;
      wr_slot <= '0;
    end else if (!busy) begin
      col     <= '0;
      line    <= '0;
      wr_slot <= '0;
    end else if (row_end) begin
      col     <= '0;
      line    <= line + size_t'(1);
      wr_slot <= (wr_slot == SWIDTH'(NMEM - 1)) ? '0 : wr_slot + SWIDTH'(1);
    end else begin
      col <= col + size_t'(1);
    end
  end

  for (genvar m = 0; m < NMEM; m++) begin : g_mem
    line_mem u_mem (
      .clk        (clk),
      .mem_we     (busy && wr_slot == SWIDTH'(m)),
      .mem_addr   (col[AWIDTH-1:0]),
      .write_data (pix_in),
      .read_data  (rd_data[m])
    );
  end

  // new column enters at fil_size-1 and moves left, unused cells stay zero
  for (genvar r = 0; r < `MAXLINE; r++) begin : g_row
    assign col_pix[r] = rd_data[row_slot(slot_q, cfg.fil_size, r)];
    for (genvar c = 0; c < `MAXLINE; c++) begin : g_col
      pixel_t from_right;
      if (c < `MAXLINE - 1) begin : g_shift
        assign from_right = window[r*`MAXLINE + c + 1];
      end else begin : g_edge
        assign from_right = '0;
      end
      assign win_next[r*`MAXLINE + c] =
          (size_t'(r) >= cfg.fil_size || size_t'(c) >= cfg.fil_size) ? '0 :
          (size_t'(c) == cfg.fil_size - size_t'(1)) ? col_pix[r] : from_right;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= wr_slot; // aligns slot select with registered read
    window <= win_next;
  end

  // two cycles from read address to a complete window
  always_ff @(posedge clk) begin
    if (!xrst) begin
      take_d    <= 1'b0;
      win_valid <= 1'b0;
    end else begin
      take_d    <= state == LB_ACTIVE && col >= cfg.fil_size - size_t'(1);
      win_valid <= take_d;
    end
  end

endmodule

/* src/line_mem.sv */
`timescale 1ns/1ns
`include "conv_macros.svh"

module line_mem import conv_pkg::*; #(
  parameter  int DEPTH  = `MAXSIZE,
  localparam int AWIDTH = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              mem_we,
  input  logic [AWIDTH-1:0] mem_addr,
  input  pixel_t            write_data,
  output pixel_t            read_data
);

  pixel_t mem [DEPTH];

  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= write_data;
    end
    read_data <= mem[mem_addr];
  end

endmodule

/* src/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

  typedef logic signed [`DWIDTH-1:0] pixel_t;
  typedef logic        [`LWIDTH-1:0] size_t;
  typedef logic signed [`WWIDTH-1:0] weight_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_AWIDTH-1:0] paddr;
    logic [`APB_DWIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DWIDTH-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_rsp_t;

  typedef struct packed {
    size_t img_size;
    size_t fil_size;
  } conv_cfg_t;

  // entry r*MAXLINE+c is row r, column c
  typedef weight_t [`MAXLINE*`MAXLINE-1:0] kernel_t;
  typedef pixel_t  [`MAXLINE*`MAXLINE-1:0] window_t;

  typedef enum logic [1:0] {LB_WAIT, LB_CHARGE, LB_ACTIVE} linebuf_state_t;

endpackage

/* src/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// filter and image limits
`define MAXLINE 5
`define MAXSIZE 32

// datapath widths
`define DWIDTH 16
`define LWIDTH 6
`define WWIDTH 8

// apb bus widths
`define APB_AWIDTH 8
`define APB_DWIDTH 32

// apb byte offsets
`define REG_CTRL   8'h00
`define REG_STATUS 8'h04
`define REG_IMG    8'h08
`define REG_FIL    8'h0C
`define REG_WGT    8'h40 // base of MAXLINE*MAXLINE weight words

`endif
